//--- design/key_input.sv
`timescale 1ns/100ps

module key_input (
  input  logic                clk,
  input  logic                nrst,
  input  logic [14:0]         keypad_i,
  output synth_pkg::key_vec_t synced_keys_o,
  output logic                octave_pulse_o,
  output logic                mode_pulse_o
);

  // Bit 13 is the octave button, bit 14 the mode button
  localparam int OCT_BIT  = 13;
  localparam int MODE_BIT = 14;

  logic [14:0] meta_q;
  logic [14:0] sync_q;
  logic [1:0]  btn_q;
  logic [1:0]  btn_rise;

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= keypad_i;
      sync_q <= meta_q;
    end
  end

  // Delayed button levels for edge detection
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      btn_q <= '0;
    end else begin
      btn_q <= sync_q[MODE_BIT:OCT_BIT];
    end
  end

  assign btn_rise       = sync_q[MODE_BIT:OCT_BIT] & ~btn_q;
  assign synced_keys_o  = sync_q[12:0];
  assign octave_pulse_o = btn_rise[0];
  assign mode_pulse_o   = btn_rise[1];

endmodule

//--- design/note_encoder.sv
`timescale 1ns/100ps

module note_encoder (
  input  logic                  clk,
  input  logic                  nrst,
  input  synth_pkg::key_vec_t   synced_keys_i,
  output synth_pkg::note_code_t note_1_o,
  output synth_pkg::note_code_t note_2_o,
  output synth_pkg::note_code_t note_3_o,
  output synth_pkg::note_code_t note_4_o,
  output synth_pkg::voice_cnt_t key_count_o
);
  import synth_pkg::*;

  key_vec_t   left;
  note_code_t code_nxt [NUM_VOICES];
  note_code_t code_q [NUM_VOICES];
  logic [3:0] total;
  voice_cnt_t count_nxt;

  // Code of the lowest set key or 0 when no key is set
  function automatic note_code_t lowest_code(input key_vec_t keys);
    note_code_t code;
    code = '0;
    for (int i = NUM_NOTES - 1; i >= 0; i--) begin
      if (keys[i]) begin
        code = note_code_t'(i + 1);
      end
    end
    return code;
  endfunction

  // Each slot takes the lowest key left, then that key is dropped
  always_comb begin
    left = synced_keys_i;
    for (int v = 0; v < NUM_VOICES; v++) begin
      code_nxt[v] = lowest_code(left);
      left        = left & (left - 1'b1);
    end
  end

  always_comb begin
    total = '0;
    for (int i = 0; i < NUM_NOTES; i++) begin
      total = total + 4'(synced_keys_i[i]);
    end
    count_nxt = (total > 4'(NUM_VOICES)) ? voice_cnt_t'(NUM_VOICES) : voice_cnt_t'(total);
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      code_q      <= '{default: '0};
      key_count_o <= '0;
    end else begin
      code_q      <= code_nxt;
      key_count_o <= count_nxt;
    end
  end

  assign note_1_o = code_q[0];
  assign note_2_o = code_q[1];
  assign note_3_o = code_q[2];
  assign note_4_o = code_q[3];

endmodule

//--- design/octave_mode_fsm.sv
`timescale 1ns/100ps

module octave_mode_fsm (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  octave_pulse_i,
  input  logic                  mode_pulse_i,
  output synth_pkg::octave_t    octave_o,
  output synth_pkg::play_mode_e mode_o
);
  import synth_pkg::*;

  play_mode_e state;
  play_mode_e state_nxt;

  always_comb begin
    state_nxt = state;
    if (mode_pulse_i) begin
      case (state)
        MODE_MONO: state_nxt = MODE_POLY;
        MODE_POLY: state_nxt = MODE_MONO;
        default:   state_nxt = MODE_MONO;
      endcase
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      state <= MODE_MONO;
    end else begin
      state <= state_nxt;
    end
  end

  // Octave wraps from 3 back to 0, mode is left alone
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      octave_o <= '0;
    end else if (octave_pulse_i) begin
      octave_o <= octave_t'(octave_o + 2'd1);
    end
  end

  assign mode_o = state;

endmodule

//--- design/synth_pkg.sv
package synth_pkg;

  typedef logic [12:0] key_vec_t;
  typedef logic [3:0]  note_code_t;
  typedef logic [2:0]  voice_cnt_t;
  typedef logic [1:0]  octave_t;
  typedef logic [2:0]  sample_t;
  typedef logic [7:0]  half_period_t;

  typedef enum logic {
    MODE_MONO = 1'b0,
    MODE_POLY = 1'b1
  } play_mode_e;

  localparam int NUM_VOICES = 4;
  localparam int NUM_NOTES  = 13;

  // Half periods in clock cycles at octave 0 with the lowest note first
  // All entries are multiples of 8 so the octave shift stays exact
  localparam half_period_t NOTE_DIV [NUM_NOTES] = '{
    8'd240, 8'd224, 8'd216, 8'd200,
    8'd192, 8'd184, 8'd168, 8'd160,
    8'd152, 8'd144, 8'd136, 8'd128,
    8'd120
  };

endpackage

//--- design/synth_top.sv
`timescale 1ns/100ps

module synth_top #(
  parameter int DIV_W = 8
) (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic [14:0]                      keypad_i,
  output synth_pkg::note_code_t            note_1_o,
  output synth_pkg::note_code_t            note_2_o,
  output synth_pkg::note_code_t            note_3_o,
  output synth_pkg::note_code_t            note_4_o,
  output synth_pkg::voice_cnt_t            key_count_o,
  output synth_pkg::octave_t               octave_o,
  output synth_pkg::play_mode_e            mode_o,
  output logic [synth_pkg::NUM_VOICES-1:0] wave_o,
  output synth_pkg::sample_t               sample_o
);
  import synth_pkg::*;

  key_vec_t synced_keys;
  logic     octave_pulse;
  logic     mode_pulse;

  key_input i_key_input (
    .clk            (clk),
    .nrst           (nrst),
    .keypad_i       (keypad_i),
    .synced_keys_o  (synced_keys),
    .octave_pulse_o (octave_pulse),
    .mode_pulse_o   (mode_pulse)
  );

  note_encoder i_note_encoder (
    .clk           (clk),
    .nrst          (nrst),
    .synced_keys_i (synced_keys),
    .note_1_o      (note_1_o),
    .note_2_o      (note_2_o),
    .note_3_o      (note_3_o),
    .note_4_o      (note_4_o),
    .key_count_o   (key_count_o)
  );

  octave_mode_fsm i_octave_mode_fsm (
    .clk            (clk),
    .nrst           (nrst),
    .octave_pulse_i (octave_pulse),
    .mode_pulse_i   (mode_pulse),
    .octave_o       (octave_o),
    .mode_o         (mode_o)
  );

  tone_divider #(.DIV_W(DIV_W)) i_tone_1 (
    .clk(clk), .nrst(nrst), .note_i(note_1_o), .octave_i(octave_o), .wave_o(wave_o[0])
  );
  tone_divider #(.DIV_W(DIV_W)) i_tone_2 (
    .clk(clk), .nrst(nrst), .note_i(note_2_o), .octave_i(octave_o), .wave_o(wave_o[1])
  );
  tone_divider #(.DIV_W(DIV_W)) i_tone_3 (
    .clk(clk), .nrst(nrst), .note_i(note_3_o), .octave_i(octave_o), .wave_o(wave_o[2])
  );
  tone_divider #(.DIV_W(DIV_W)) i_tone_4 (
    .clk(clk), .nrst(nrst), .note_i(note_4_o), .octave_i(octave_o), .wave_o(wave_o[3])
  );

  voice_mixer i_voice_mixer (
    .wave_i   (wave_o),
    .mode_i   (mode_o),
    .sample_o (sample_o)
  );

endmodule

//--- design/tone_divider.sv
`timescale 1ns/100ps

module tone_divider #(
  parameter int DIV_W = 8
) (
  input  logic                  clk,
  input  logic                  nrst,
  input  synth_pkg::note_code_t note_i,
  input  synth_pkg::octave_t    octave_i,
  output logic                  wave_o
);
  import synth_pkg::*;

  note_code_t       note_q;
  octave_t          octave_q;
  half_period_t     base;
  logic [DIV_W-1:0] half;
  logic [DIV_W-1:0] cnt;
  logic             restart;

  // Codes outside 1 to 13 stay silent
  always_comb begin
    if (note_i != '0 && note_i <= NUM_NOTES) begin
      base = NOTE_DIV[note_i - 1'b1];
    end else begin
      base = '0;
    end
  end

  assign half    = DIV_W'(base) >> octave_i;
  assign restart = (note_i != note_q) || (octave_i != octave_q);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      note_q   <= '0;
      octave_q <= '0;
      cnt      <= '0;
      wave_o   <= 1'b0;
    end else begin
      note_q   <= note_i;
      octave_q <= octave_i;
      if (restart || base == '0) begin
        cnt    <= half - 1'b1;
        wave_o <= 1'b0;
      end else if (cnt == '0) begin
        cnt    <= half - 1'b1;
        wave_o <= ~wave_o;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

//--- design/voice_mixer.sv
`timescale 1ns/100ps

module voice_mixer (
  input  logic [synth_pkg::NUM_VOICES-1:0] wave_i,
  input  synth_pkg::play_mode_e             mode_i,
  output synth_pkg::sample_t                sample_o
);
  import synth_pkg::*;

  sample_t poly_sum;

  // Silent voices hold their wave low, so a plain sum is enough
  always_comb begin
    poly_sum = '0;
    for (int v = 0; v < NUM_VOICES; v++) begin
      poly_sum = poly_sum + sample_t'(wave_i[v]);
    end
  end

  always_comb begin
    case (mode_i)
      MODE_POLY: sample_o = poly_sum;
      // Mono keeps only the first voice
      default:   sample_o = sample_t'(wave_i[0]);
    endcase
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_synth_top -f synth_top.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }

//--- synth_top.f
design/synth_pkg.sv
design/key_input.sv
design/note_encoder.sv
design/octave_mode_fsm.sv
design/tone_divider.sv
design/voice_mixer.sv
design/synth_top.sv
test/synth_checker.sv
test/tb_synth_top.sv

//--- test/synth_checker.sv
`timescale 1ns/100ps

module synth_checker (
  input  logic                             clk,
  input  logic                             nrst,
  input  synth_pkg::note_code_t            note_1_i,
  input  synth_pkg::note_code_t            note_2_i,
  input  synth_pkg::note_code_t            note_3_i,
  input  synth_pkg::note_code_t            note_4_i,
  input  synth_pkg::voice_cnt_t            key_count_i,
  input  synth_pkg::octave_t               octave_i,
  input  synth_pkg::play_mode_e            mode_i,
  input  logic [synth_pkg::NUM_VOICES-1:0] wave_i,
  input  synth_pkg::sample_t               sample_i
);
  import synth_pkg::*;

  int   pass_cnt = 0;
  int   fail_cnt = 0;
  int   test_errs = 0;
  int   half_exp = 0;
  int   edges = 0;
  int   cyc = 0;
  int   last_edge = 0;
  int   mix_exp;
  logic wave_prev = 1'b0;
  logic measuring = 1'b0;

  task automatic check_value(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("FAILED %s expected 0x%0h got 0x%0h", name, exp, act);
      test_errs++;
    end
  endtask

  // Mixer rule and wave period are watched on every falling edge
  always @(negedge clk) begin
    cyc++;
    mix_exp = (mode_i == MODE_POLY) ? $countones(wave_i) : int'(wave_i[0]);
    if (nrst && int'(sample_i) != mix_exp) begin
      $display("FAILED sample_o expected 0x%0h got 0x%0h", mix_exp, sample_i);
      test_errs++;
    end
    if (measuring && wave_i[0] != wave_prev) begin
      if (edges > 0) begin
        check_value("wave_o[0] half period", half_exp, cyc - last_edge);
      end
      edges++;
      last_edge = cyc;
    end
    wave_prev = wave_i[0];
  end

  task automatic arm_period(input int base, input int oct);
    half_exp  = base >> oct;
    edges     = 0;
    measuring = 1'b1;
  endtask

  task automatic compare(input int id, input int kind, input logic [12:0] keys,
                         input int oct, input int mode, input int n1, n2, n3, n4,
                         input int count);
    int exp_note [4];
    int exp_cnt;
    exp_note = '{n1, n2, n3, n4};
    exp_cnt  = count;
    // Random patterns fill the slots with the lowest keys in order
    if (kind == 1) begin
      exp_note = '{0, 0, 0, 0};
      exp_cnt  = 0;
      for (int i = 0; i < 13; i++) begin
        if (keys[i] && exp_cnt < 4) begin
          exp_note[exp_cnt] = i + 1;
          exp_cnt++;
        end
      end
    end
    check_value("octave_o", oct, int'(octave_i));
    check_value("mode_o", (mode != 0) ? int'(MODE_POLY) : int'(MODE_MONO), int'(mode_i));
    check_value("note_1_o", exp_note[0], int'(note_1_i));
    check_value("note_2_o", exp_note[1], int'(note_2_i));
    check_value("note_3_o", exp_note[2], int'(note_3_i));
    check_value("note_4_o", exp_note[3], int'(note_4_i));
    check_value("key_count_o", exp_cnt, int'(key_count_i));
    if (exp_cnt == 0) begin
      check_value("sample_o", 0, int'(sample_i));
    end
    if (kind == 2) begin
      if (edges < 3) begin
        $display("test %0d: wave_o[0] did not toggle often enough to measure a period", id);
        test_errs++;
      end
      measuring = 1'b0;
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0d keys 0x%h passed", id, keys);
    end else begin
      fail_cnt++;
      $display("test %0d keys 0x%h failed with %0d errors", id, keys, test_errs);
    end
    test_errs = 0;
  endtask

endmodule

//--- test/synth_vectors.txt
# kind keypad(hex) hold octave mode note1 note2 note3 note4 count half
# kind 0 fixed, 1 random keys, 2 tone period, 3 long button hold; half is at octave 0
0 0000 12 0 0 0 0 0 0 0 0
0 0001 8 0 0 1 0 0 0 1 0
0 1000 8 0 0 13 0 0 0 1 0
0 0a5a 8 0 0 2 4 5 7 4 0
0 1fff 8 0 0 1 2 3 4 4 0
0 1111 8 0 0 1 5 9 13 4 0
1 0000 8 0 0 0 0 0 0 0 0
1 0000 8 0 0 0 0 0 0 0 0
1 0000 8 0 0 0 0 0 0 0 0
2 0001 800 0 0 1 0 0 0 1 240
2 1000 700 0 0 13 0 0 0 1 120
0 2000 8 1 0 0 0 0 0 0 0
3 2000 40 2 0 0 0 0 0 0 0
0 2000 8 3 0 0 0 0 0 0 0
0 2000 8 0 0 0 0 0 0 0 0
0 2000 8 1 0 0 0 0 0 0 0
0 2000 8 2 0 0 0 0 0 0 0
2 0001 300 2 0 1 0 0 0 1 240
0 4000 8 2 1 0 0 0 0 0 0
0 0a5a 400 2 1 2 4 5 7 4 0
3 4000 40 2 0 0 0 0 0 0 0
0 1111 300 2 0 1 5 9 13 4 0
1 0000 8 2 0 0 0 0 0 0 0

//--- test/tb_synth_top.sv
`timescale 1ns/100ps

module tb_synth_top;
  import synth_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_TESTS    = 64;
  localparam int NUM_FIELDS   = 11;
  // Columns of the vector file
  localparam int F_KIND  = 0;
  localparam int F_KEYS  = 1;
  localparam int F_HOLD  = 2;
  localparam int F_OCT   = 3;
  localparam int F_MODE  = 4;
  localparam int F_NOTE  = 5;
  localparam int F_COUNT = 9;
  localparam int F_HALF  = 10;
  localparam int KIND_RANDOM = 1;
  localparam int KIND_PERIOD = 2;
  localparam int KIND_LONG   = 3;

  logic                  clk;
  logic                  nrst;
  logic [14:0]           keypad;
  note_code_t            note_1;
  note_code_t            note_2;
  note_code_t            note_3;
  note_code_t            note_4;
  voice_cnt_t            key_count;
  octave_t               octave;
  play_mode_e            mode;
  logic [NUM_VOICES-1:0] wave;
  sample_t               sample;

  int          vec [MAX_TESTS][NUM_FIELDS];
  int          num_tests = 0;
  int          bad_lines = 0;
  int          limit_cycles = 0;
  logic [31:0] seed = 32'h3a26_cdaf;

  synth_top #(.DIV_W(8)) i_dut (
    .clk(clk), .nrst(nrst), .keypad_i(keypad),
    .note_1_o(note_1), .note_2_o(note_2), .note_3_o(note_3), .note_4_o(note_4),
    .key_count_o(key_count), .octave_o(octave), .mode_o(mode),
    .wave_o(wave), .sample_o(sample)
  );

  synth_checker i_chk (
    .clk(clk), .nrst(nrst),
    .note_1_i(note_1), .note_2_i(note_2), .note_3_i(note_3), .note_4_i(note_4),
    .key_count_i(key_count), .octave_i(octave), .mode_i(mode),
    .wave_i(wave), .sample_i(sample)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_vectors();
    int    fd;
    int    got;
    string line;
    fd = $fopen("test/synth_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open test/synth_vectors.txt");
      bad_lines++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      got = $sscanf(line, "%d %h %d %d %d %d %d %d %d %d %d",
                    vec[num_tests][0], vec[num_tests][1], vec[num_tests][2],
                    vec[num_tests][3], vec[num_tests][4], vec[num_tests][5],
                    vec[num_tests][6], vec[num_tests][7], vec[num_tests][8],
                    vec[num_tests][9], vec[num_tests][10]);
      if (got == NUM_FIELDS && num_tests < MAX_TESTS - 1) begin
        num_tests++;
      end else begin
        $display("vector line could not be read: %s", line);
        bad_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t);
    logic [14:0] keys;
    int          kind;
    int          btn_cycles;
    kind = vec[t][F_KIND];
    keys = 15'(vec[t][F_KEYS]);
    if (kind == KIND_RANDOM) begin
      seed = lcg_next(seed);
      keys = {2'b00, seed[28:16]};
    end
    btn_cycles = (kind == KIND_LONG) ? vec[t][F_HOLD] - 4 : 4;
    @(posedge clk);
    keypad <= keys;
    for (int c = 1; c < vec[t][F_HOLD]; c++) begin
      @(posedge clk);
      // Buttons are released, note keys stay down
      if (c == btn_cycles) keypad <= {2'b00, keys[12:0]};
      if (kind == KIND_PERIOD && c == 6) begin
        @(negedge clk);
        #1;
        i_chk.arm_period(vec[t][F_HALF], vec[t][F_OCT]);
      end
    end
    @(negedge clk);
    #1;
    i_chk.compare(t, kind, keys[12:0], vec[t][F_OCT], vec[t][F_MODE],
                  vec[t][F_NOTE], vec[t][F_NOTE+1], vec[t][F_NOTE+2], vec[t][F_NOTE+3],
                  vec[t][F_COUNT]);
  endtask

  initial begin
    nrst   = 1'b0;
    keypad = '0;
    load_vectors();
    limit_cycles = RESET_CYCLES + 100;
    for (int t = 0; t < num_tests; t++) begin
      limit_cycles += vec[t][F_HOLD] + 4;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    nrst <= 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests passed %0d failed %0d", i_chk.pass_cnt, i_chk.fail_cnt);
    if (i_chk.fail_cnt == 0 && num_tests > 0 && bad_lines == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the hold lengths in the vector file
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the vectors did not finish", limit_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
